// File: Bender.yml
package:
  name: mips_pipe

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mips_pipe_pkg.sv
      - logic/fetch_stage.sv
      - logic/reg_file.sv
      - logic/decode_stage.sv
      - logic/hazard_unit.sv
      - logic/exec_stage.sv
      - logic/mem_wb_stage.sv
      - logic/mips_pipe_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/mips_pipe_chk.sv
      - verif/mips_pipe_tb.sv

// File: logic/decode_stage.sv
`timescale 1ns/1ps

`include "mips_pipe_settings.svh"

module decode_stage import mips_pipe_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  instr_t    instr_i,
    input  logic      bubble_i,
    input  reg_addr_t wb_addr_i,
    input  word_t     wb_data_i,
    input  logic      wb_we_i,
    output reg_addr_t rs_d_o,
    output reg_addr_t rt_d_o,
    output reg_addr_t rs_e_o,
    output reg_addr_t rt_e_o,
    output reg_addr_t dst_e_o,
    output word_t     rd1_e_o,
    output word_t     rd2_e_o,
    output word_t     imm_e_o,
    output alu_ctrl_t alu_ctrl_e_o,
    output logic      use_imm_e_o,
    output logic      reg_we_e_o,
    output logic      mem_to_reg_e_o,
    output logic      mem_we_e_o
);

    opcode_t   op;
    funct_t    fn;
    reg_addr_t rd;
    word_t     rd1;
    word_t     rd2;
    word_t     imm;
    alu_ctrl_t alu_ctrl;
    logic      use_imm;
    logic      reg_we;
    logic      mem_to_reg;
    logic      mem_we;
    logic      dst_is_rd;

    // Field split
    assign op     = instr_i[31:26];
    assign rs_d_o = instr_i[25:21];
    assign rt_d_o = instr_i[20:16];
    assign rd     = instr_i[15:11];
    assign fn     = instr_i[5:0];
    assign imm    = {{(`MIPS_XLEN-16){instr_i[15]}}, instr_i[15:0]};

    reg_file u_rf (
        .clk_i (clk_i),
        .ra1_i (rs_d_o),
        .ra2_i (rt_d_o),
        .rd1_o (rd1),
        .rd2_o (rd2),
        .wa_i  (wb_addr_i),
        .wd_i  (wb_data_i),
        .we_i  (wb_we_i)
    );

    // Main decoder
    // Anything unrecognised falls through with no write enables
    always_comb
    begin
        alu_ctrl   = `MIPS_ALU_ADD;
        use_imm    = 1'b0;
        reg_we     = 1'b0;
        mem_to_reg = 1'b0;
        mem_we     = 1'b0;
        dst_is_rd  = 1'b0;
        case (op)
            `MIPS_OP_RTYPE:
            begin
                dst_is_rd = 1'b1;
                reg_we    = 1'b1;
                case (fn)
                    `MIPS_FN_ADD: alu_ctrl = `MIPS_ALU_ADD;
                    `MIPS_FN_SUB: alu_ctrl = `MIPS_ALU_SUB;
                    `MIPS_FN_AND: alu_ctrl = `MIPS_ALU_AND;
                    `MIPS_FN_OR:  alu_ctrl = `MIPS_ALU_OR;
                    `MIPS_FN_SLT: alu_ctrl = `MIPS_ALU_SLT;
                    // Shifts and others are dropped
                    default:      reg_we   = 1'b0;
                endcase
            end
            `MIPS_OP_LW:
            begin
                use_imm    = 1'b1;
                reg_we     = 1'b1;
                mem_to_reg = 1'b1;
            end
            `MIPS_OP_SW:
            begin
                use_imm = 1'b1;
                mem_we  = 1'b1;
            end
            `MIPS_OP_ADDI:
            begin
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            default:
            begin
                reg_we = 1'b0;
            end
        endcase
    end

    // Decode-to-execute control, bubble kills write enables only
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i || bubble_i)
        begin
            reg_we_e_o     <= 1'b0;
            mem_to_reg_e_o <= 1'b0;
            mem_we_e_o     <= 1'b0;
        end
        else
        begin
            reg_we_e_o     <= reg_we;
            mem_to_reg_e_o <= mem_to_reg;
            mem_we_e_o     <= mem_we;
        end
    end

    // Decode-to-execute payload
    always_ff @(posedge clk_i)
    begin
        rs_e_o       <= rs_d_o;
        rt_e_o       <= rt_d_o;
        dst_e_o      <= dst_is_rd ? rd : rt_d_o;
        rd1_e_o      <= rd1;
        rd2_e_o      <= rd2;
        imm_e_o      <= imm;
        alu_ctrl_e_o <= alu_ctrl;
        use_imm_e_o  <= use_imm;
    end

endmodule

// File: logic/exec_stage.sv
`timescale 1ns/1ps

`include "mips_pipe_settings.svh"

module exec_stage import mips_pipe_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  word_t     rd1_i,
    input  word_t     rd2_i,
    input  word_t     imm_i,
    input  reg_addr_t dst_i,
    input  alu_ctrl_t alu_ctrl_i,
    input  logic      use_imm_i,
    input  logic      reg_we_i,
    input  logic      mem_to_reg_i,
    input  logic      mem_we_i,
    input  fwd_sel_t  fwd_a_i,
    input  fwd_sel_t  fwd_b_i,
    input  word_t     wb_data_i,
    output word_t     alu_m_o,
    output word_t     wdata_m_o,
    output reg_addr_t dst_m_o,
    output logic      reg_we_m_o,
    output logic      mem_to_reg_m_o,
    output logic      mem_we_m_o
);

    word_t src_a;
    word_t reg_b;
    word_t src_b;
    word_t alu_res;

    // Operand source select
    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            `MIPS_FWD_MEM: return mem_val;
            `MIPS_FWD_WB:  return wb_val;
            default:       return reg_val;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a_i, rd1_i, alu_m_o, wb_data_i);
    assign reg_b = fwd_mux(fwd_b_i, rd2_i, alu_m_o, wb_data_i);
    // Immediate for addi, lw and sw; store data keeps the register
    assign src_b = use_imm_i ? imm_i : reg_b;

    always_comb
    begin
        case (alu_ctrl_i)
            `MIPS_ALU_AND: alu_res = src_a & src_b;
            `MIPS_ALU_OR:  alu_res = src_a | src_b;
            `MIPS_ALU_SUB: alu_res = src_a - src_b;
            `MIPS_ALU_SLT: alu_res = ($signed(src_a) < $signed(src_b)) ? word_t'(1) : '0;
            default:       alu_res = src_a + src_b;
        endcase
    end

    // Execute-to-memory control
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            reg_we_m_o     <= 1'b0;
            mem_to_reg_m_o <= 1'b0;
            mem_we_m_o     <= 1'b0;
        end
        else
        begin
            reg_we_m_o     <= reg_we_i;
            mem_to_reg_m_o <= mem_to_reg_i;
            mem_we_m_o     <= mem_we_i;
        end
    end

    // Execute-to-memory payload
    always_ff @(posedge clk_i)
    begin
        alu_m_o   <= alu_res;
        wdata_m_o <= reg_b;
        dst_m_o   <= dst_i;
    end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

`include "mips_pipe_settings.svh"

module fetch_stage import mips_pipe_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   stall_i,
    input  instr_t instr_i,
    output word_t  pc_o,
    output instr_t instr_d_o
);

    word_t pc_q;

    // PC steps by one word, frozen during a load-use stall
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            pc_q <= `MIPS_RESET_PC;
        else if (!stall_i)
            pc_q <= pc_q + word_t'(4);
    end

    assign pc_o = pc_q;

    // Fetch-to-decode register
    // All-zero word decodes as a no-op, so reset loads it
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            instr_d_o <= '0;
        else if (!stall_i)
            instr_d_o <= instr_i;
    end

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

`include "mips_pipe_settings.svh"

module hazard_unit import mips_pipe_pkg::*;
(
    input  reg_addr_t rs_d_i,
    input  reg_addr_t rt_d_i,
    input  reg_addr_t rs_e_i,
    input  reg_addr_t rt_e_i,
    input  reg_addr_t dst_e_i,
    input  reg_addr_t dst_m_i,
    input  reg_addr_t dst_w_i,
    input  logic      load_e_i,
    input  logic      reg_we_m_i,
    input  logic      reg_we_w_i,
    output logic      stall_o,
    output fwd_sel_t  fwd_a_o,
    output fwd_sel_t  fwd_b_o
);

    // Memory stage is younger, so it wins over writeback
    function automatic fwd_sel_t pick_src(input reg_addr_t src, input reg_addr_t dst_m,
                                          input logic we_m, input reg_addr_t dst_w,
                                          input logic we_w);
        fwd_sel_t sel;
        sel = `MIPS_FWD_REG;
        if (src != '0)
        begin
            if (we_m && (dst_m == src))
                sel = `MIPS_FWD_MEM;
            else if (we_w && (dst_w == src))
                sel = `MIPS_FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_a_o = pick_src(rs_e_i, dst_m_i, reg_we_m_i, dst_w_i, reg_we_w_i);
    assign fwd_b_o = pick_src(rt_e_i, dst_m_i, reg_we_m_i, dst_w_i, reg_we_w_i);

    // Load data only exists after memory, one cycle too late for
    // the instruction right behind it
    assign stall_o = load_e_i && (dst_e_i != '0)
                   && ((dst_e_i == rs_d_i) || (dst_e_i == rt_d_i));

endmodule

// File: logic/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage import mips_pipe_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  word_t     alu_i,
    input  word_t     rdata_i,
    input  reg_addr_t dst_i,
    input  logic      reg_we_i,
    input  logic      mem_to_reg_i,
    output word_t     wb_data_o,
    output reg_addr_t wb_addr_o,
    output logic      wb_we_o
);

    word_t alu_w;
    word_t rdata_w;
    logic  mem_to_reg_w;

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            wb_we_o      <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end
        else
        begin
            wb_we_o      <= reg_we_i;
            mem_to_reg_w <= mem_to_reg_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        alu_w     <= alu_i;
        rdata_w   <= rdata_i;
        wb_addr_o <= dst_i;
    end

    // Load data or ALU result
    assign wb_data_o = mem_to_reg_w ? rdata_w : alu_w;

endmodule

// File: logic/mips_pipe_pkg.sv
`include "mips_pipe_settings.svh"

package mips_pipe_pkg;

    // Data word, also used for addresses and the PC
    typedef logic [`MIPS_XLEN-1:0] word_t;

    // Raw instruction as fetched
    typedef logic [31:0] instr_t;

    // Register number, 32 architectural registers
    typedef logic [`MIPS_RADDR_W-1:0] reg_addr_t;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // ALU operation select
    typedef logic [2:0] alu_ctrl_t;

    // Operand source for execute:
    // register value, memory-stage result or writeback result
    typedef logic [1:0] fwd_sel_t;

endpackage

// File: logic/mips_pipe_settings.svh
`ifndef MIPS_PIPE_SETTINGS_SVH
`define MIPS_PIPE_SETTINGS_SVH

// Datapath and register file widths
`define MIPS_XLEN       32
`define MIPS_RADDR_W    5
`define MIPS_RESET_PC   32'h0000_0000

// Opcodes of the supported instructions
`define MIPS_OP_RTYPE   6'b000000
`define MIPS_OP_LW      6'b100011
`define MIPS_OP_SW      6'b101011
`define MIPS_OP_ADDI    6'b001000

// R-type function codes
`define MIPS_FN_ADD     6'b100000
`define MIPS_FN_SUB     6'b100010
`define MIPS_FN_AND     6'b100100
`define MIPS_FN_OR      6'b100101
`define MIPS_FN_SLT     6'b101010

// ALU operation select, classic MIPS encoding
`define MIPS_ALU_AND    3'b000
`define MIPS_ALU_OR     3'b001
`define MIPS_ALU_ADD    3'b010
`define MIPS_ALU_SUB    3'b110
`define MIPS_ALU_SLT    3'b111

// Execute operand source
`define MIPS_FWD_REG    2'b00
`define MIPS_FWD_WB     2'b01
`define MIPS_FWD_MEM    2'b10

`endif

// File: logic/mips_pipe_top.sv
`timescale 1ns/1ps

module mips_pipe_top import mips_pipe_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  instr_t instr_i,
    output word_t  pc_o,
    output word_t  dmem_addr_o,
    output word_t  dmem_wdata_o,
    output logic   dmem_we_o,
    input  word_t  dmem_rdata_i
);

    instr_t    instr_d;
    logic      stall;
    reg_addr_t rs_d;
    reg_addr_t rt_d;
    reg_addr_t rs_e;
    reg_addr_t rt_e;
    reg_addr_t dst_e;
    word_t     rd1_e;
    word_t     rd2_e;
    word_t     imm_e;
    alu_ctrl_t alu_ctrl_e;
    logic      use_imm_e;
    logic      reg_we_e;
    logic      mem_to_reg_e;
    logic      mem_we_e;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    reg_addr_t dst_m;
    logic      reg_we_m;
    logic      mem_to_reg_m;
    word_t     wb_data;
    reg_addr_t wb_addr;
    logic      wb_we;

    fetch_stage u_fetch (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .stall_i   (stall),
        .instr_i   (instr_i),
        .pc_o      (pc_o),
        .instr_d_o (instr_d)
    );

    decode_stage u_decode (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_i        (instr_d),
        .bubble_i       (stall),
        .wb_addr_i      (wb_addr),
        .wb_data_i      (wb_data),
        .wb_we_i        (wb_we),
        .rs_d_o         (rs_d),
        .rt_d_o         (rt_d),
        .rs_e_o         (rs_e),
        .rt_e_o         (rt_e),
        .dst_e_o        (dst_e),
        .rd1_e_o        (rd1_e),
        .rd2_e_o        (rd2_e),
        .imm_e_o        (imm_e),
        .alu_ctrl_e_o   (alu_ctrl_e),
        .use_imm_e_o    (use_imm_e),
        .reg_we_e_o     (reg_we_e),
        .mem_to_reg_e_o (mem_to_reg_e),
        .mem_we_e_o     (mem_we_e)
    );

    // Only lw sets mem_to_reg, so it marks a load in execute
    hazard_unit u_hazard (
        .rs_d_i     (rs_d),
        .rt_d_i     (rt_d),
        .rs_e_i     (rs_e),
        .rt_e_i     (rt_e),
        .dst_e_i    (dst_e),
        .dst_m_i    (dst_m),
        .dst_w_i    (wb_addr),
        .load_e_i   (mem_to_reg_e),
        .reg_we_m_i (reg_we_m),
        .reg_we_w_i (wb_we),
        .stall_o    (stall),
        .fwd_a_o    (fwd_a),
        .fwd_b_o    (fwd_b)
    );

    // Memory-stage registers drive the data port directly
    exec_stage u_exec (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .rd1_i          (rd1_e),
        .rd2_i          (rd2_e),
        .imm_i          (imm_e),
        .dst_i          (dst_e),
        .alu_ctrl_i     (alu_ctrl_e),
        .use_imm_i      (use_imm_e),
        .reg_we_i       (reg_we_e),
        .mem_to_reg_i   (mem_to_reg_e),
        .mem_we_i       (mem_we_e),
        .fwd_a_i        (fwd_a),
        .fwd_b_i        (fwd_b),
        .wb_data_i      (wb_data),
        .alu_m_o        (dmem_addr_o),
        .wdata_m_o      (dmem_wdata_o),
        .dst_m_o        (dst_m),
        .reg_we_m_o     (reg_we_m),
        .mem_to_reg_m_o (mem_to_reg_m),
        .mem_we_m_o     (dmem_we_o)
    );

    mem_wb_stage u_mem_wb (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .alu_i        (dmem_addr_o),
        .rdata_i      (dmem_rdata_i),
        .dst_i        (dst_m),
        .reg_we_i     (reg_we_m),
        .mem_to_reg_i (mem_to_reg_m),
        .wb_data_o    (wb_data),
        .wb_addr_o    (wb_addr),
        .wb_we_o      (wb_we)
    );

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import mips_pipe_pkg::*;
(
    input  logic      clk_i,
    input  reg_addr_t ra1_i,
    input  reg_addr_t ra2_i,
    output word_t     rd1_o,
    output word_t     rd2_o,
    input  reg_addr_t wa_i,
    input  word_t     wd_i,
    input  logic      we_i
);

    word_t regs [2**$bits(reg_addr_t)];

    // Register zero never written
    always_ff @(posedge clk_i)
    begin
        if (we_i && (wa_i != '0))
            regs[wa_i] <= wd_i;
    end

    // Reads see a same-cycle writeback, r0 reads as zero
    always_comb
    begin
        if (ra1_i == '0)
            rd1_o = '0;
        else if (we_i && (wa_i == ra1_i))
            rd1_o = wd_i;
        else
            rd1_o = regs[ra1_i];

        if (ra2_i == '0)
            rd2_o = '0;
        else if (we_i && (wa_i == ra2_i))
            rd2_o = wd_i;
        else
            rd2_o = regs[ra2_i];
    end

endmodule

// File: mips_pipe.f
+incdir+logic
logic/mips_pipe_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/exec_stage.sv
logic/mem_wb_stage.sv
logic/mips_pipe_top.sv
verif/mips_pipe_chk.sv
verif/mips_pipe_tb.sv

// File: verif/mips_pipe_chk.sv
`timescale 1ns/1ps

`include "mips_pipe_settings.svh"

module mips_pipe_chk import mips_pipe_pkg::*;
(
    input logic      clk_i,
    input logic      rst_n_i,
    input word_t     pc_i,
    input logic      dmem_we_i,
    input logic      load_e_i,
    input reg_addr_t dst_e_i,
    input reg_addr_t rs_d_i,
    input reg_addr_t rt_d_i
);

    // Failed assertion count
    int   fail_cnt = 0;
    logic load_use;

    // Load in execute feeding a source field of the decode instruction
    assign load_use = load_e_i && (dst_e_i != '0)
                    && ((dst_e_i == rs_d_i) || (dst_e_i == rt_d_i));

    // First cycle out of reset shows the reset PC
    reset_pc_a: assert property (@(posedge clk_i) $rose(rst_n_i) |-> pc_i == `MIPS_RESET_PC)
    else
    begin
        $error("pc not at the reset PC after reset");
        fail_cnt++;
    end

    // No store strobe during or right after reset
    reset_we_a: assert property (@(posedge clk_i) !rst_n_i |=> !dmem_we_i)
    else
    begin
        $error("dmem_we_o high during reset");
        fail_cnt++;
    end

    // Hold exactly one cycle after a load-use
    pc_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) && $past(load_use) |-> pc_i == $past(pc_i))
    else
    begin
        $error("pc moved during a load-use stall");
        fail_cnt++;
    end

    pc_step_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) && !$past(load_use) |-> pc_i == $past(pc_i) + 32'd4)
    else
    begin
        $error("pc did not advance by four");
        fail_cnt++;
    end

endmodule

// File: verif/mips_pipe_tb.sv
`timescale 1ns/1ps

`include "mips_pipe_settings.svh"

module mips_pipe_tb import mips_pipe_pkg::*;
();

    logic   clk_i;
    logic   rst_n_i;
    instr_t instr_i;
    word_t  pc_o;
    word_t  dmem_addr_o;
    word_t  dmem_wdata_o;
    logic   dmem_we_o;
    word_t  dmem_rdata_i;

    instr_t    rom  [512];
    word_t     dram [64];
    word_t     mmem [64];
    word_t     mreg [32];
    word_t     exp_addr [$];
    word_t     exp_data [$];
    int        seed = 32'ha8bc02c6;
    int        prog_len = 0;
    int        exp_cnt = 0;
    int        store_idx = 0;
    reg_addr_t last_dst = '0;

    mips_pipe_top uut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .pc_o         (pc_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i)
    );

    bind mips_pipe_top mips_pipe_chk u_chk (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .pc_i       (pc_o),
        .dmem_we_i  (dmem_we_o),
        .load_e_i   (mem_to_reg_e),
        .dst_e_i    (dst_e),
        .rs_d_i     (rs_d),
        .rt_d_i     (rt_d)
    );

    // Memories answer in the same cycle
    assign instr_i      = rst_n_i ? rom[pc_o[10:2]] : '0;
    assign dmem_rdata_i = rst_n_i ? dram[dmem_addr_o[7:2]] : '0;

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Half the time reuse the last destination to build dependency chains
    function automatic reg_addr_t src_reg();
        return (rand_below(2) == 0) ? last_dst : reg_addr_t'(rand_below(32));
    endfunction

    // Every address bit changes the word
    function automatic word_t fill_word(input int idx);
        return 32'h1000_0000 + word_t'(idx) * 32'h0101_0103;
    endfunction

    function automatic funct_t alu_funct(input int k);
        case (k)
            0:       return `MIPS_FN_ADD;
            1:       return `MIPS_FN_SUB;
            2:       return `MIPS_FN_AND;
            3:       return `MIPS_FN_OR;
            default: return `MIPS_FN_SLT;
        endcase
    endfunction

    function automatic instr_t r_type(input funct_t fn, input reg_addr_t rd,
                                      input reg_addr_t rs, input reg_addr_t rt);
        return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    // Destination or store data first, then base, then immediate
    function automatic instr_t i_type(input opcode_t op, input reg_addr_t rt,
                                      input reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // In-order reference, one instruction at a time
    task automatic model_step(input instr_t ins);
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     res;
        reg_addr_t dst;
        logic      we;
        a   = mreg[ins[25:21]];
        b   = mreg[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        dst = ins[20:16];
        res = '0;
        we  = 1'b1;
        case (ins[31:26])
            `MIPS_OP_RTYPE:
            begin
                dst = ins[15:11];
                case (ins[5:0])
                    `MIPS_FN_ADD: res = a + b;
                    `MIPS_FN_SUB: res = a - b;
                    `MIPS_FN_AND: res = a & b;
                    `MIPS_FN_OR:  res = a | b;
                    `MIPS_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:      we  = 1'b0;
                endcase
            end
            `MIPS_OP_LW:   res = mmem[(a + imm) >> 2];
            `MIPS_OP_ADDI: res = a + imm;
            `MIPS_OP_SW:
            begin
                we = 1'b0;
                mmem[(a + imm) >> 2] = b;
                exp_addr.push_back(a + imm);
                exp_data.push_back(b);
            end
            default: we = 1'b0;
        endcase
        if (we && (dst != '0))
            mreg[dst] = res;
    endtask

    task automatic emit(input instr_t ins);
        rom[prog_len] = ins;
        prog_len++;
        model_step(ins);
    endtask

    task automatic build_program();
        int          kept;
        int unsigned kind;
        reg_addr_t   dst;
        logic [31:0] rnd;
        logic [15:0] off;
        // r30 is the data base at word 16, never a random destination
        for (int k = 1; k < 32; k++)
            emit(i_type(`MIPS_OP_ADDI, reg_addr_t'(k), 5'd0,
                        (k == 30) ? 16'd64 : 16'($random(seed))));
        // Dependent chain at distance one and two
        emit(r_type(`MIPS_FN_ADD, 5'd5, 5'd1, 5'd2));
        emit(r_type(`MIPS_FN_SUB, 5'd6, 5'd5, 5'd3));
        emit(r_type(`MIPS_FN_AND, 5'd7, 5'd5, 5'd6));
        emit(r_type(`MIPS_FN_OR, 5'd8, 5'd7, 5'd5));
        emit(r_type(`MIPS_FN_SLT, 5'd9, 5'd8, 5'd6));
        emit(i_type(`MIPS_OP_SW, 5'd9, 5'd30, 16'd0));
        emit(i_type(`MIPS_OP_SW, 5'd8, 5'd30, 16'd4));
        // Negative immediates, signed compare
        emit(i_type(`MIPS_OP_ADDI, 5'd10, 5'd0, 16'hfffb));
        emit(i_type(`MIPS_OP_ADDI, 5'd11, 5'd10, 16'hff00));
        emit(r_type(`MIPS_FN_SLT, 5'd12, 5'd11, 5'd10));
        emit(r_type(`MIPS_FN_SLT, 5'd13, 5'd10, 5'd12));
        emit(i_type(`MIPS_OP_SW, 5'd12, 5'd30, 16'd8));
        emit(i_type(`MIPS_OP_SW, 5'd13, 5'd30, 16'd12));
        // Computed base, store and reload, then two load-use stalls
        emit(i_type(`MIPS_OP_ADDI, 5'd17, 5'd30, 16'd40));
        emit(i_type(`MIPS_OP_SW, 5'd11, 5'd17, 16'hfffc));
        emit(i_type(`MIPS_OP_LW, 5'd14, 5'd17, 16'hfffc));
        emit(r_type(`MIPS_FN_ADD, 5'd15, 5'd14, 5'd14));
        emit(i_type(`MIPS_OP_SW, 5'd15, 5'd17, 16'd4));
        emit(i_type(`MIPS_OP_LW, 5'd16, 5'd30, 16'hffc0));
        emit(i_type(`MIPS_OP_SW, 5'd16, 5'd30, 16'd20));
        last_dst = 5'd16;
        kept = 0;
        while (kept < 200)
        begin
            kind = rand_below(9);
            dst  = reg_addr_t'(rand_below(30));
            rnd  = $random(seed);
            off  = 16'(rand_below(64) * 4 - 64);
            if (kind < 5)
                emit(r_type(alu_funct(kind), dst, src_reg(), src_reg()));
            else if (kind == 5)
                emit(i_type(`MIPS_OP_ADDI, dst, src_reg(), rnd[15:0]));
            else if (kind == 6)
                emit(i_type(`MIPS_OP_LW, dst, 5'd30, off));
            else if (kind == 7)
                emit(i_type(`MIPS_OP_SW, src_reg(), 5'd30, off));
            // Dropped beq and sll encodings
            else if (rnd[31])
                emit({6'b000100, rnd[25:0]});
            else
                emit({6'b000000, rnd[25:6], 6'b000000});
            if (kind < 7)
                last_dst = dst;
            if (kind < 8)
                kept++;
        end
        // Dump every register
        for (int k = 0; k < 32; k++)
            emit(i_type(`MIPS_OP_SW, reg_addr_t'(k), 5'd30, 16'(k * 4 - 64)));
    endtask

    // Data RAM write port and in-order store compare
    always @(posedge clk_i)
    begin
        if (rst_n_i && dmem_we_o)
        begin
            dram[dmem_addr_o[7:2]] <= dmem_wdata_o;
            if (store_idx >= exp_cnt)
            begin
                $display("Store to %h beyond the %0d expected stores", dmem_addr_o, exp_cnt);
                $display("TEST FAILED");
                $fatal(1, "extra store");
            end
            else
            begin
                store_addr_a: assert (dmem_addr_o == exp_addr[store_idx])
                else
                begin
                    $display("FAIL dmem_addr_o: got %h, expected %h", dmem_addr_o,
                             exp_addr[store_idx]);
                    $display("TEST FAILED");
                    $fatal(1, "store address mismatch");
                end
                store_data_a: assert (dmem_wdata_o == exp_data[store_idx])
                else
                begin
                    $display("FAIL dmem_wdata_o: got %h, expected %h", dmem_wdata_o,
                             exp_data[store_idx]);
                    $display("TEST FAILED");
                    $fatal(1, "store data mismatch");
                end
                store_idx = store_idx + 1;
            end
        end
    end

    // Bound checker errors stop the run
    always @(posedge clk_i)
    begin
        if (uut.u_chk.fail_cnt != 0)
        begin
            $display("A port rule assertion in the checker failed");
            $display("TEST FAILED");
            $fatal(1, "checker error");
        end
    end

    initial
    begin : watchdog
        @(posedge rst_n_i);
        repeat (2 * prog_len + 50) @(posedge clk_i);
        $display("Stores did not finish: %0d of %0d seen", store_idx, exp_cnt);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin : main_flow
        rst_n_i = 1'b0;
        for (int i = 0; i < 512; i++)
            rom[i] = '0;
        for (int i = 0; i < 64; i++)
        begin
            dram[i] = fill_word(i);
            mmem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++)
            mreg[i] = '0;
        build_program();
        exp_cnt = exp_addr.size();
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        wait (store_idx == exp_cnt);
        repeat (5) @(posedge clk_i);
        if (uut.u_chk.fail_cnt == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("TEST FAILED");
            $fatal(1, "run ended with errors");
        end
    end

endmodule
